/* soc_ctrl.f */
+incdir+hdl
hdl/soc_ctrl_pkg.sv
hdl/apb_addr_decode.sv
hdl/rtc_tick_sync.sv
hdl/clint_timer.sv
hdl/debug_req_gate.sv
hdl/soc_ctrl_top.sv
bench/tb_clk_gen.sv
bench/soc_ctrl_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module soc_ctrl_tb -f soc_ctrl.f

status=0
out=$(./obj_dir/Vsoc_ctrl_tb 2>&1) || status=$?
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'PASS: all tests'; then
  echo "simulation passed"
else
  echo "simulation failed, exit status $status"
  exit 1
fi

/* bench/soc_ctrl_tb.sv */
// --------------------------------------------------------------------------
// Testbench for the timer and debug-request controller
// Stops at the first failing check; every wait is bounded by 2000 cycles
// rtc_i is stepped from the clk_i domain, one toggle every 4 cycles
// --------------------------------------------------------------------------
`timescale 1ns/10ps
`include "soc_ctrl_defs.svh"
`default_nettype none

module soc_ctrl_tb;
  import soc_ctrl_pkg::*;

  localparam int unsigned TIMEOUT = 2000;
  localparam logic [31:0] MTIME_ADDR = `CLINT_BASE + 32'(`MTIME_OFS);
  localparam logic [31:0] HALT_ADDR  = `DBG_BASE + 32'(`HALTREQ_OFS);

  logic                  clk;
  logic                  ndmreset_n;
  logic                  rtc;
  apb_req_t              apb_req;
  apb_rsp_t              apb_rsp;
  logic [`NUM_HARTS-1:0] dbg_req_in;
  logic [`NUM_HARTS-1:0] timer_irq;
  logic [`NUM_HARTS-1:0] ipi;
  logic [`NUM_HARTS-1:0] dbg_req_out;

  // Expected register state, updated at the edge that ends a write
  logic [`NUM_HARTS-1:0] exp_msip = '0;
  logic [`NUM_HARTS-1:0] exp_halt = '0;
  logic [`NUM_HARTS-1:0] exp_dbg;
  int unsigned           cyc_cnt = 0;
  int unsigned           rtc_div = 0;
  int unsigned           rtc_rises = 0;

  tb_clk_gen u_tb_clk_gen (
    .clk_o        ( clk        ),
    .ndmreset_n_o ( ndmreset_n )
  );

  soc_ctrl_top u_soc_ctrl_top (
    .clk_i       ( clk         ),
    .ndmreset_n  ( ndmreset_n  ),
    .rtc_i       ( rtc         ),
    .apb_req_i   ( apb_req     ),
    .apb_rsp_o   ( apb_rsp     ),
    .debug_req_i ( dbg_req_in  ),
    .timer_irq_o ( timer_irq   ),
    .ipi_o       ( ipi         ),
    .debug_req_o ( dbg_req_out )
  );

  // Cycles since reset release, saturating
  always @(posedge clk or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      cyc_cnt <= 0;
    end else if (cyc_cnt < 32'd100000) begin
      cyc_cnt <= cyc_cnt + 1;
    end
  end

  assign exp_dbg = (cyc_cnt < `DMI_DEL_CYCLES) ? {`NUM_HARTS{1'b0}} : (exp_halt | dbg_req_in);

  task automatic abort_run();
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    a_value : assert (act === exp) else begin
      $display("error at %0t: %s expected %h got %h", $time, name, exp, act);
      abort_run();
    end
  endtask

  // ------------------------------------------------------------------------
  // Output checks, sampled in the middle of the cycle
  // ------------------------------------------------------------------------
  a_debug_gate : assert property (
    @(negedge clk) disable iff (!ndmreset_n) dbg_req_out == exp_dbg
  ) else begin
    $display("error at %0t: debug_req_o expected %b got %b", $time, exp_dbg, dbg_req_out);
    abort_run();
  end

  a_ipi : assert property (
    @(negedge clk) disable iff (!ndmreset_n) ipi == exp_msip
  ) else begin
    $display("error at %0t: ipi_o expected %b got %b", $time, exp_msip, ipi);
    abort_run();
  end

  a_no_wait : assert property (
    @(negedge clk) disable iff (!ndmreset_n)
    (apb_req.psel && apb_req.penable) |-> apb_rsp.pready
  ) else begin
    $display("error at %0t: pready expected 1 got %b", $time, apb_rsp.pready);
    abort_run();
  end

  function automatic logic [31:0] cmp_addr(input int hart, input int word);
    return `CLINT_BASE + 32'(`MTIMECMP_OFS) + 32'(8 * hart + 4 * word);
  endfunction

  function automatic logic [31:0] msip_addr(input int hart);
    return `CLINT_BASE + 32'(`MSIP_OFS) + 32'(4 * hart);
  endfunction

  // Ticks come from the 1st, 3rd, 5th ... rising edge of rtc_i
  function automatic int unsigned odd_edges(input int unsigned first, input int unsigned last);
    int unsigned n;
    n = 0;
    for (int unsigned k = first + 1; k <= last; k++) begin
      if (k % 2 == 1) begin
        n++;
      end
    end
    return n;
  endfunction

  task automatic apb_xfer(input logic write, input logic [31:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
    @(posedge clk);
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= write;
    apb_req.paddr   <= addr;
    apb_req.pwdata  <= wdata;
    @(posedge clk);
    apb_req.penable <= 1'b1;
    @(negedge clk);
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    @(posedge clk);
    apb_req.psel    <= 1'b0;
    apb_req.penable <= 1'b0;
  endtask

  task automatic reg_write(input logic [31:0] addr, input logic [31:0] wdata);
    logic [31:0] rdata;
    logic        err;
    apb_xfer(1'b1, addr, wdata, rdata, err);
    check_value("pslverr", 64'd0, 64'(err));
  endtask

  task automatic reg_read(input logic [31:0] addr, output logic [31:0] rdata);
    logic err;
    apb_xfer(1'b0, addr, 32'd0, rdata, err);
    check_value("pslverr", 64'd0, 64'(err));
  endtask

  // One clk_i cycle of the rtc_i stimulus
  task automatic rtc_step();
    @(posedge clk);
    rtc_div = rtc_div + 1;
    if (rtc_div == 4) begin
      rtc_div = 0;
      if (!rtc) begin
        rtc_rises = rtc_rises + 1;
      end
      rtc <= ~rtc;
    end
  endtask

  task automatic run_rtc(input int unsigned edges);
    int unsigned target;
    target = rtc_rises + edges;
    for (int i = 0; i < TIMEOUT && rtc_rises < target; i++) begin
      rtc_step();
    end
    if (rtc_rises < target) begin
      $display("timeout: rtc_i did not reach %0d rising edges", target);
      abort_run();
    end
  endtask

  initial begin
    logic [31:0] rd;
    logic [31:0] rd_hi;
    logic [31:0] wd;
    logic [31:0] wd_hi;
    logic        err;
    logic [63:0] target;
    int unsigned start;
    apb_req    = '0;
    rtc        = 1'b0;
    dbg_req_in = '1;
    void'($urandom(32'h5020_88f9));

    // Reset values and the post-reset debug gate
    for (int i = 0; i < TIMEOUT && !ndmreset_n; i++) begin
      @(negedge clk);
    end
    if (!ndmreset_n) begin
      $display("timeout: ndmreset_n was not released");
      abort_run();
    end
    check_value("timer_irq_o", 64'd0, 64'(timer_irq));
    check_value("ipi_o", 64'd0, 64'(ipi));
    for (int i = 0; i < TIMEOUT && cyc_cnt < `DMI_DEL_CYCLES + 2; i++) begin
      @(negedge clk);
    end
    check_value("debug_req_o", 64'(2'b11), 64'(dbg_req_out));
    @(posedge clk);
    dbg_req_in <= '0;

    // Register read back
    for (int h = 0; h < `NUM_HARTS; h++) begin
      wd    = $urandom();
      wd_hi = $urandom();
      reg_write(cmp_addr(h, 0), wd);
      reg_write(cmp_addr(h, 1), wd_hi);
      reg_read(cmp_addr(h, 0), rd);
      reg_read(cmp_addr(h, 1), rd_hi);
      check_value("mtimecmp", {wd_hi, wd}, {rd_hi, rd});
      wd = $urandom();
      reg_write(msip_addr(h), wd);
      exp_msip[h] <= wd[0];
      reg_read(msip_addr(h), rd);
      check_value("msip", 64'(wd[0]), 64'(rd));
    end
    wd = $urandom();
    reg_write(HALT_ADDR, wd);
    exp_halt <= wd[`NUM_HARTS-1:0];
    reg_read(HALT_ADDR, rd);
    check_value("haltreq", 64'(wd[`NUM_HARTS-1:0]), 64'(rd));
    apb_xfer(1'b0, 32'h0400_0000, 32'd0, rd, err);
    check_value("pslverr", 64'd1, 64'(err));
    check_value("prdata", 64'd0, 64'(rd));
    apb_xfer(1'b1, `CLINT_BASE + `CLINT_LEN, $urandom(), rd, err);
    check_value("pslverr", 64'd1, 64'(err));

    // mtime count over a known number of rtc_i edges, with a low word carry
    reg_write(MTIME_ADDR, 32'hFFFF_FFFE);
    reg_write(MTIME_ADDR + 32'd4, 32'h0000_0001);
    start = rtc_rises;
    run_rtc(7);
    repeat (10) @(posedge clk);
    reg_read(MTIME_ADDR, rd);
    reg_read(MTIME_ADDR + 32'd4, rd_hi);
    check_value("mtime", 64'h1_FFFF_FFFE + 64'(odd_edges(start, rtc_rises)), {rd_hi, rd});

    // Timer interrupt on hart 0 only
    target = {rd_hi, rd} + 64'd3;
    reg_write(cmp_addr(1, 0), 32'hFFFF_FFFF);
    reg_write(cmp_addr(1, 1), 32'hFFFF_FFFF);
    reg_write(cmp_addr(0, 1), 32'hFFFF_FFFF);
    reg_write(cmp_addr(0, 0), target[31:0]);
    reg_write(cmp_addr(0, 1), target[63:32]);
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_value("timer_irq_o", 64'd0, 64'(timer_irq));
    for (int i = 0; i < TIMEOUT && !timer_irq[0]; i++) begin
      rtc_step();
      @(negedge clk);
      check_value("timer_irq_o[1]", 64'd0, 64'(timer_irq[1]));
    end
    if (!timer_irq[0]) begin
      $display("timeout: timer_irq_o[0] did not rise");
      abort_run();
    end
    reg_read(MTIME_ADDR, rd);
    reg_read(MTIME_ADDR + 32'd4, rd_hi);
    check_value("mtime reached mtimecmp[0]", 64'd1, 64'({rd_hi, rd} >= target));
    reg_write(cmp_addr(0, 0), 32'hFFFF_FFFF);
    reg_write(cmp_addr(0, 1), 32'hFFFF_FFFF);
    for (int i = 0; i < TIMEOUT && timer_irq[0]; i++) begin
      @(negedge clk);
    end
    check_value("timer_irq_o", 64'd0, 64'(timer_irq));

    // Software interrupts, then halt requests with debug_req_i low
    for (int h = 0; h < `NUM_HARTS; h++) begin
      reg_write(msip_addr(h), 32'd0);
      exp_msip[h] <= 1'b0;
    end
    for (int h = 0; h < `NUM_HARTS; h++) begin
      reg_write(msip_addr(h), 32'd1);
      exp_msip <= `NUM_HARTS'(1 << h);
      @(negedge clk);
      check_value("ipi_o", 64'(1 << h), 64'(ipi));
      reg_write(msip_addr(h), 32'd0);
      exp_msip <= '0;
      @(negedge clk);
      check_value("ipi_o", 64'd0, 64'(ipi));
    end
    for (int p = 1; p <= 4; p++) begin
      wd = 32'(p % 4);
      reg_write(HALT_ADDR, wd);
      exp_halt <= wd[`NUM_HARTS-1:0];
      @(negedge clk);
      check_value("debug_req_o", 64'(wd[`NUM_HARTS-1:0]), 64'(dbg_req_out));
    end

    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire

/* bench/tb_clk_gen.sv */
// --------------------------------------------------------------------------
// Testbench clock and reset, 20 ns period
// Reset is released with a non-blocking update on the 4th rising edge
// --------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic ndmreset_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  initial begin
    ndmreset_n_o = 1'b0;
    repeat (4) @(posedge clk_o);
    ndmreset_n_o <= 1'b1;
  end

endmodule

`default_nettype wire

/* hdl/soc_ctrl_top.sv */
// --------------------------------------------------------------------------
// Timer and debug-request controller, APB slave port
// Single clock domain clk_i; rtc_i is only sampled by the tick synchronizer
// --------------------------------------------------------------------------
`timescale 1ns/10ps
`include "soc_ctrl_defs.svh"
`default_nettype none

module soc_ctrl_top (
  input  logic                    clk_i,
  input  logic                    ndmreset_n,
  input  logic                    rtc_i,
  input  soc_ctrl_pkg::apb_req_t  apb_req_i,
  output soc_ctrl_pkg::apb_rsp_t  apb_rsp_o,
  input  logic [`NUM_HARTS-1:0]   debug_req_i,
  output logic [`NUM_HARTS-1:0]   timer_irq_o,
  output logic [`NUM_HARTS-1:0]   ipi_o,
  output logic [`NUM_HARTS-1:0]   debug_req_o
);
  import soc_ctrl_pkg::*;

  reg_req_t           clint_req;
  reg_req_t           dbg_req;
  logic [`APB_DW-1:0] clint_rdata;
  logic [`APB_DW-1:0] dbg_rdata;
  logic               rtc_tick;

  apb_addr_decode u_apb_addr_decode (
    .clk_i         ( clk_i       ),
    .ndmreset_n    ( ndmreset_n  ),
    .apb_req_i     ( apb_req_i   ),
    .apb_rsp_o     ( apb_rsp_o   ),
    .clint_req_o   ( clint_req   ),
    .clint_rdata_i ( clint_rdata ),
    .dbg_req_o     ( dbg_req     ),
    .dbg_rdata_i   ( dbg_rdata   )
  );

  rtc_tick_sync u_rtc_tick_sync (
    .clk_i      ( clk_i      ),
    .ndmreset_n ( ndmreset_n ),
    .rtc_i      ( rtc_i      ),
    .tick_o     ( rtc_tick   )
  );

  clint_timer u_clint_timer (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .reg_req_i   ( clint_req   ),
    .rdata_o     ( clint_rdata ),
    .tick_i      ( rtc_tick    ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

  debug_req_gate u_debug_req_gate (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .reg_req_i   ( dbg_req     ),
    .rdata_o     ( dbg_rdata   ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o )
  );

endmodule

`default_nettype wire

/* hdl/debug_req_gate.sv */
// --------------------------------------------------------------------------
// Halt-request register and post-reset gate on debug requests
// Requests stay low for DMI_DEL_CYCLES cycles after reset release
// After that window the output follows its inputs combinationally
// --------------------------------------------------------------------------
`timescale 1ns/10ps
`include "soc_ctrl_defs.svh"
`default_nettype none

module debug_req_gate (
  input  logic                    clk_i,
  input  logic                    ndmreset_n,
  input  soc_ctrl_pkg::reg_req_t  reg_req_i,
  output logic [`APB_DW-1:0]      rdata_o,
  input  logic [`NUM_HARTS-1:0]   debug_req_i,
  output logic [`NUM_HARTS-1:0]   debug_req_o
);
  import soc_ctrl_pkg::*;

  localparam logic [13:0] HALTREQ_W = 14'(`HALTREQ_OFS >> 2);

  logic [`NUM_HARTS-1:0] haltreq_q;
  gate_cnt_t             gate_cnt_q;
  logic                  haltreq_sel;

  assign haltreq_sel = (reg_req_i.offset[15:2] == HALTREQ_W);

  always_ff @(posedge clk_i or negedge ndmreset_n) begin : p_haltreq
    if (!ndmreset_n) begin
      haltreq_q <= '0;
    end else if (reg_req_i.valid && reg_req_i.write && haltreq_sel) begin
      haltreq_q <= reg_req_i.wdata[`NUM_HARTS-1:0];
    end
  end

  // Gives the harts time to run boot code before a halt can land
  always_ff @(posedge clk_i or negedge ndmreset_n) begin : p_del_cnt
    if (!ndmreset_n) begin
      gate_cnt_q <= gate_cnt_t'(`DMI_DEL_CYCLES);
    end else if (gate_cnt_q != '0) begin
      gate_cnt_q <= gate_cnt_q - 1'b1;
    end
  end

  assign debug_req_o = (gate_cnt_q != '0) ? '0 : (haltreq_q | debug_req_i);
  assign rdata_o     = haltreq_sel ? `APB_DW'(haltreq_q) : '0;

  a_gate_closed : assert property (
    @(posedge clk_i) disable iff (!ndmreset_n)
    (gate_cnt_q != '0) |-> (debug_req_o == '0)
  );

endmodule

`default_nettype wire

/* hdl/clint_timer.sv */
// --------------------------------------------------------------------------
// CLINT-style timer with mtime, per-hart mtimecmp and msip
// Register access is 32 bits wide; 64-bit registers are split low/high
// Offset bits [1:0] are ignored, unknown words read as zero
// An mtime write in the same cycle as a tick discards the tick
// --------------------------------------------------------------------------
`timescale 1ns/10ps
`include "soc_ctrl_defs.svh"
`default_nettype none

module clint_timer (
  input  logic                    clk_i,
  input  logic                    ndmreset_n,
  input  soc_ctrl_pkg::reg_req_t  reg_req_i,
  output logic [`APB_DW-1:0]      rdata_o,
  input  logic                    tick_i,
  output logic [`NUM_HARTS-1:0]   timer_irq_o,
  output logic [`NUM_HARTS-1:0]   ipi_o
);
  import soc_ctrl_pkg::*;

  // Word addresses of the register blocks
  localparam logic [13:0] MSIP_W     = 14'(`MSIP_OFS >> 2);
  localparam logic [13:0] MTIMECMP_W = 14'(`MTIMECMP_OFS >> 2);
  localparam logic [13:0] MTIME_W    = 14'(`MTIME_OFS >> 2);

  timer64_t              mtime_q;
  timer64_t              mtime_d;
  timer64_t              mtimecmp_q [`NUM_HARTS];
  logic [`NUM_HARTS-1:0] msip_q;
  logic [`NUM_HARTS-1:0] timer_irq_q;
  logic [13:0]           word_addr;
  logic                  wr_en;
  logic                  mtime_lo_wr;
  logic                  mtime_hi_wr;
  logic                  mtime_wr;

  assign word_addr   = reg_req_i.offset[15:2];
  assign wr_en       = reg_req_i.valid & reg_req_i.write;
  assign mtime_lo_wr = wr_en & (word_addr == MTIME_W);
  assign mtime_hi_wr = wr_en & (word_addr == MTIME_W + 14'd1);
  assign mtime_wr    = mtime_lo_wr | mtime_hi_wr;

  // ------------------------------------------------------------------------
  // mtime next state
  // ------------------------------------------------------------------------
  always_comb begin : p_mtime_next
    mtime_d = mtime_q;
    if (mtime_wr) begin
      if (mtime_lo_wr) begin
        mtime_d[31:0] = reg_req_i.wdata;
      end
      if (mtime_hi_wr) begin
        mtime_d[63:32] = reg_req_i.wdata;
      end
    end else if (tick_i) begin
      mtime_d = mtime_q + 64'd1;
    end
  end

  // ------------------------------------------------------------------------
  // Registers and interrupt outputs
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin : p_regs
    if (!ndmreset_n) begin
      mtime_q     <= '0;
      msip_q      <= '0;
      timer_irq_q <= '0;
      for (int h = 0; h < `NUM_HARTS; h++) begin
        mtimecmp_q[h] <= '1;
      end
    end else begin
      mtime_q <= mtime_d;
      for (int h = 0; h < `NUM_HARTS; h++) begin
        if (wr_en && word_addr == MSIP_W + 14'(h)) begin
          msip_q[h] <= reg_req_i.wdata[0];
        end
        if (wr_en && word_addr == MTIMECMP_W + 14'(2 * h)) begin
          mtimecmp_q[h][31:0] <= reg_req_i.wdata;
        end
        if (wr_en && word_addr == MTIMECMP_W + 14'(2 * h + 1)) begin
          mtimecmp_q[h][63:32] <= reg_req_i.wdata;
        end
        // Unsigned 64-bit compare, seen one cycle later on the output
        timer_irq_q[h] <= (mtime_q >= mtimecmp_q[h]);
      end
    end
  end

  assign timer_irq_o = timer_irq_q;
  assign ipi_o       = msip_q;

  // Read mux
  always_comb begin : p_read
    rdata_o = '0;
    if (word_addr == MTIME_W) begin
      rdata_o = mtime_q[31:0];
    end
    if (word_addr == MTIME_W + 14'd1) begin
      rdata_o = mtime_q[63:32];
    end
    for (int h = 0; h < `NUM_HARTS; h++) begin
      if (word_addr == MSIP_W + 14'(h)) begin
        rdata_o = `APB_DW'(msip_q[h]);
      end
      if (word_addr == MTIMECMP_W + 14'(2 * h)) begin
        rdata_o = mtimecmp_q[h][31:0];
      end
      if (word_addr == MTIMECMP_W + 14'(2 * h + 1)) begin
        rdata_o = mtimecmp_q[h][63:32];
      end
    end
  end

  // Only the bus may move mtime backwards
  a_mtime_monotonic : assert property (
    @(posedge clk_i) disable iff (!ndmreset_n)
    !mtime_wr |=> (mtime_q >= $past(mtime_q))
  );

endmodule

`default_nettype wire

/* hdl/rtc_tick_sync.sv */
// --------------------------------------------------------------------------
// Divides rtc_i by two and brings it into the clk_i domain as a tick
// rtc_i must be slower than clk_i by at least a factor of four
// One tick per two rising edges of rtc_i, first tick on the first edge
// --------------------------------------------------------------------------
`timescale 1ns/10ps
`include "soc_ctrl_defs.svh"
`default_nettype none

module rtc_tick_sync (
  input  logic clk_i,
  input  logic ndmreset_n,
  input  logic rtc_i,
  output logic tick_o
);
  import soc_ctrl_pkg::*;

  logic        rtc_tgl_q;
  sync_chain_t sync_q;
  logic        prev_q;
  logic        tick_q;

  // Divide by two in the rtc domain
  always_ff @(posedge rtc_i or negedge ndmreset_n) begin : p_rtc_div
    if (!ndmreset_n) begin
      rtc_tgl_q <= 1'b0;
    end else begin
      rtc_tgl_q <= ~rtc_tgl_q;
    end
  end

  // ------------------------------------------------------------------------
  // Synchronizer and rising-edge detect in clk_i
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin : p_sync
    if (!ndmreset_n) begin
      sync_q <= '0;
      prev_q <= 1'b0;
      tick_q <= 1'b0;
    end else begin
      sync_q <= {sync_q[`SYNC_STAGES-2:0], rtc_tgl_q};
      prev_q <= sync_q[`SYNC_STAGES-1];
      // registered so mtime moves 3 to 4 cycles after the rtc edge
      tick_q <= sync_q[`SYNC_STAGES-1] & ~prev_q;
    end
  end

  assign tick_o = tick_q;

  // Ticks stay at least four cycles apart while rtc_i keeps its rate limit
  a_tick_single : assert property (
    @(posedge clk_i) disable iff (!ndmreset_n)
    tick_o |-> (!$past(tick_o) && !$past(tick_o, 2) && !$past(tick_o, 3))
  );

endmodule

`default_nettype wire

/* hdl/apb_addr_decode.sv */
// --------------------------------------------------------------------------
// APB slave with a two-entry address rule table
// No wait states: pready is high in every access cycle
// Unmapped addresses answer with pslverr and zero read data
// --------------------------------------------------------------------------
`timescale 1ns/10ps
`include "soc_ctrl_defs.svh"
`default_nettype none

module apb_addr_decode (
  input  logic                    clk_i,
  input  logic                    ndmreset_n,
  input  soc_ctrl_pkg::apb_req_t  apb_req_i,
  output soc_ctrl_pkg::apb_rsp_t  apb_rsp_o,
  output soc_ctrl_pkg::reg_req_t  clint_req_o,
  input  logic [`APB_DW-1:0]      clint_rdata_i,
  output soc_ctrl_pkg::reg_req_t  dbg_req_o,
  input  logic [`APB_DW-1:0]      dbg_rdata_i
);
  import soc_ctrl_pkg::*;

  localparam int unsigned NUM_RULES = 2;

  localparam addr_rule_t ADDR_MAP [NUM_RULES] = '{
    '{region: REGION_CLINT, start_addr: `CLINT_BASE, end_addr: `CLINT_BASE + `CLINT_LEN},
    '{region: REGION_DBG,   start_addr: `DBG_BASE,   end_addr: `DBG_BASE + `DBG_LEN}
  };

  apb_phase_e             phase_q;
  logic                   access;
  region_e                hit_region;
  logic [`REG_OFS_W-1:0]  hit_offset;

  // ------------------------------------------------------------------------
  // Phase tracking
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin : p_phase
    if (!ndmreset_n) begin
      phase_q <= PH_IDLE;
    end else if (apb_req_i.psel && !apb_req_i.penable) begin
      phase_q <= PH_ACCESS;
    end else begin
      phase_q <= PH_IDLE;
    end
  end

  assign access = (phase_q == PH_ACCESS) & apb_req_i.psel & apb_req_i.penable;

  // ------------------------------------------------------------------------
  // Rule match
  // ------------------------------------------------------------------------
  always_comb begin : p_match
    hit_region = REGION_NONE;
    hit_offset = '0;
    for (int i = 0; i < NUM_RULES; i++) begin
      if (apb_req_i.paddr >= ADDR_MAP[i].start_addr &&
          apb_req_i.paddr <  ADDR_MAP[i].end_addr) begin
        hit_region = ADDR_MAP[i].region;
        hit_offset = `REG_OFS_W'(apb_req_i.paddr - ADDR_MAP[i].start_addr);
      end
    end
  end

  // Both targets see the same offset and data, only valid differs
  assign clint_req_o.valid  = access & (hit_region == REGION_CLINT);
  assign clint_req_o.write  = apb_req_i.pwrite;
  assign clint_req_o.offset = hit_offset;
  assign clint_req_o.wdata  = apb_req_i.pwdata;

  assign dbg_req_o.valid  = access & (hit_region == REGION_DBG);
  assign dbg_req_o.write  = apb_req_i.pwrite;
  assign dbg_req_o.offset = hit_offset;
  assign dbg_req_o.wdata  = apb_req_i.pwdata;

  always_comb begin : p_resp
    case (hit_region)
      REGION_CLINT: apb_rsp_o.prdata = clint_rdata_i;
      REGION_DBG:   apb_rsp_o.prdata = dbg_rdata_i;
      default:      apb_rsp_o.prdata = '0;
    endcase
    apb_rsp_o.pready  = access;
    apb_rsp_o.pslverr = access & (hit_region == REGION_NONE);
  end

  // Every access cycle must be preceded by a setup cycle
  a_setup_before_access : assert property (
    @(posedge clk_i) disable iff (!ndmreset_n)
    !apb_req_i.psel |=> !apb_req_i.penable
  );

endmodule

`default_nettype wire

/* hdl/soc_ctrl_pkg.sv */
// --------------------------------------------------------------------------
// Shared types for the APB port, the address rules and register access
// All widths come from the defs header
// --------------------------------------------------------------------------
`include "soc_ctrl_defs.svh"
`default_nettype none

package soc_ctrl_pkg;

  // APB request, driven by the bus master
  typedef struct packed {
    logic               psel;
    logic               penable;
    logic               pwrite;
    logic [`APB_AW-1:0] paddr;
    logic [`APB_DW-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [`APB_DW-1:0] prdata;
    logic               pready;
    logic               pslverr;
  } apb_rsp_t;

  typedef enum logic [1:0] {
    REGION_CLINT,
    REGION_DBG,
    REGION_NONE
  } region_e;

  // End address is exclusive
  typedef struct packed {
    region_e            region;
    logic [`APB_AW-1:0] start_addr;
    logic [`APB_AW-1:0] end_addr;
  } addr_rule_t;

  // Single-cycle register access toward one target
  typedef struct packed {
    logic                  valid;
    logic                  write;
    logic [`REG_OFS_W-1:0] offset;
    logic [`APB_DW-1:0]    wdata;
  } reg_req_t;

  typedef enum logic {
    PH_IDLE,
    PH_ACCESS
  } apb_phase_e;

  typedef logic [`SYNC_STAGES-1:0]                  sync_chain_t;
  typedef logic [63:0]                              timer64_t;
  typedef logic [$clog2(`DMI_DEL_CYCLES + 1)-1:0]   gate_cnt_t;

endpackage

`default_nettype wire

/* hdl/soc_ctrl_defs.svh */
// --------------------------------------------------------------------------
// Build-time constants for the timer and debug-request controller
// Region bases and lengths must stay aligned to their own length
// Register offsets are byte offsets inside a region, 16 bits wide
// --------------------------------------------------------------------------
`ifndef SOC_CTRL_DEFS_SVH
`define SOC_CTRL_DEFS_SVH
`default_nettype none

// Harts served by the timer and the debug gate
`define NUM_HARTS 2

// APB bus widths
`define APB_AW 32
`define APB_DW 32
`define REG_OFS_W 16

// Region map
`define CLINT_BASE 32'h0200_0000
`define CLINT_LEN 32'h0001_0000
`define DBG_BASE 32'h0300_0000
`define DBG_LEN 32'h0000_1000

// CLINT register offsets
`define MSIP_OFS 16'h0000
`define MTIMECMP_OFS 16'h4000
`define MTIME_OFS 16'hBFF8

// Debug region register offsets
`define HALTREQ_OFS 16'h0000

// Timing
`define DMI_DEL_CYCLES 500
`define SYNC_STAGES 2

`default_nettype wire
`endif
